//--- Makefile
TOP := tb_frame_reader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module frame_reader_top src/frame_reader_top.sv
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
src/vdma_pkg.sv
src/read_burst_sched.sv
src/axi_ar_issue.sv
src/line_fifo.sv
src/word_unpacker.sv
src/video_timing.sv
src/frame_reader_top.sv
tests/frame_reader_checker.sv
tests/frame_reader_asserts.sv
tests/tb_frame_reader.sv

//--- src/axi_ar_issue.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ar_issue (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  vdma_pkg::ar_req_t               req,
    input  logic                            axi_arready,
    output logic [vdma_pkg::ASIZE-1:0]      axi_araddr,
    output logic [vdma_pkg::LSIZE-1:0]      axi_arlen,
    output logic [2:0]                      axi_arsize,
    output logic [1:0]                      axi_arburst,
    output logic                            axi_arvalid,
    output logic                            ar_busy
);

    // INCR bursts only
    localparam logic [1:0] BURST_INCR = 2'b01;

    // arvalid up one cycle after the strobe, down after the handshake
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            axi_arvalid <= 1'b0;
        end else if (req_valid) begin
            axi_arvalid <= 1'b1;
        end else if (axi_arready) begin
            axi_arvalid <= 1'b0;
        end
    end

    // address and length held stable while arvalid waits
    always_ff @(posedge clock) begin
        if (req_valid) begin
            axi_araddr <= req.addr;
            axi_arlen  <= req.len;
        end
    end

    // full bus width per beat
    assign axi_arsize  = 3'($clog2(vdma_pkg::BYTES_PER_WORD));
    assign axi_arburst = BURST_INCR;

    // covers the strobe cycle too, so the scheduler cannot double issue
    assign ar_busy = req_valid | axi_arvalid;

endmodule

`default_nettype wire

//--- src/frame_reader_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_reader_top #(
    parameter int BURST_LEN  = 16,
    // power of two, at least twice BURST_LEN
    parameter int FIFO_DEPTH = 64,
    parameter int H_BLANK    = 32,
    parameter int V_BLANK    = 4,
    parameter int HSYNC_W    = 8
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        enable,
    input  vdma_pkg::frame_cfg_t        cfg,
    input  logic                        axi_arready,
    input  vdma_pkg::axi_word_t         axi_rdata,
    // response and last are not needed, beat counts come from the scheduler
    input  logic [1:0]                  axi_rresp,
    input  logic                        axi_rlast,
    input  logic                        axi_rvalid,
    output logic [vdma_pkg::ASIZE-1:0]  axi_araddr,
    output logic [vdma_pkg::LSIZE-1:0]  axi_arlen,
    output logic [2:0]                  axi_arsize,
    output logic [1:0]                  axi_arburst,
    output logic                        axi_arvalid,
    output logic                        axi_rready,
    output vdma_pkg::sync_t             out_sync,
    output vdma_pkg::pixel_t            odata
);

    // feedback from the timing stage
    logic                           frame_start;
    logic                           pix_rd;
    logic                           req_valid;
    vdma_pkg::ar_req_t              req;
    logic                           ar_busy;
    logic                           wr_beat;
    logic [$clog2(FIFO_DEPTH):0]    level;
    logic                           fifo_rd;
    vdma_pkg::axi_word_t            fifo_word;
    logic                           fifo_empty;

    read_burst_sched #(
        .BURST_LEN  (BURST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sched (
        .clock       (clock),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .cfg         (cfg),
        .level       (level),
        .wr_beat     (wr_beat),
        .ar_busy     (ar_busy),
        .req_valid   (req_valid),
        .req         (req)
    );

    axi_ar_issue u_ar (
        .clock       (clock),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arvalid (axi_arvalid),
        .ar_busy     (ar_busy)
    );

    line_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock       (clock),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .axi_rdata   (axi_rdata),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .wr_beat     (wr_beat),
        .fifo_rd     (fifo_rd),
        .fifo_word   (fifo_word),
        .fifo_empty  (fifo_empty),
        .level       (level)
    );

    word_unpacker u_unpack (
        .clock       (clock),
        .rst_n       (rst_n),
        .pix_rd      (pix_rd),
        .fifo_word   (fifo_word),
        .fifo_empty  (fifo_empty),
        .fifo_rd     (fifo_rd),
        .odata       (odata)
    );

    video_timing #(
        .H_BLANK (H_BLANK),
        .V_BLANK (V_BLANK),
        .HSYNC_W (HSYNC_W)
    ) u_timing (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .cfg         (cfg),
        .frame_start (frame_start),
        .pix_rd      (pix_rd),
        .out_sync    (out_sync)
    );

endmodule

`default_nettype wire

//--- src/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        frame_start,
    input  vdma_pkg::axi_word_t         axi_rdata,
    input  logic                        axi_rvalid,
    output logic                        axi_rready,
    output logic                        wr_beat,
    input  logic                        fifo_rd,
    output vdma_pkg::axi_word_t         fifo_word,
    output logic                        fifo_empty,
    output logic [$clog2(FIFO_DEPTH):0] level
);

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = PW + 1;

    vdma_pkg::axi_word_t    mem [FIFO_DEPTH];
    logic [PW-1:0]          wptr;
    logic [PW-1:0]          rptr;
    logic                   full;

    // depth is a power of two, so the top count bit means full
    assign full       = level[PW];
    assign fifo_empty = (level == '0);
    assign axi_rready = !full;
    // one R beat accepted
    assign wr_beat    = axi_rvalid && axi_rready;

    // pointers and count, frame start empties the queue at once
    always_ff @(posedge clock) begin
        if (!rst_n || frame_start) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            if (wr_beat) begin
                wptr <= wptr + 1'b1;
            end
            if (fifo_rd) begin
                rptr <= rptr + 1'b1;
            end
            level <= level + CW'(wr_beat) - CW'(fifo_rd);
        end
    end

    // storage and registered read port
    always_ff @(posedge clock) begin
        if (wr_beat) begin
            mem[wptr] <= axi_rdata;
        end
        // word shows up the cycle after the read strobe
        if (fifo_rd) begin
            fifo_word <= mem[rptr];
        end
    end

endmodule

`default_nettype wire

//--- src/read_burst_sched.sv
`timescale 1ns/1ps
`default_nettype none

module read_burst_sched #(
    parameter int BURST_LEN  = 16,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        frame_start,
    input  vdma_pkg::frame_cfg_t        cfg,
    input  logic [$clog2(FIFO_DEPTH):0] level,
    input  logic                        wr_beat,
    input  logic                        ar_busy,
    output logic                        req_valid,
    output vdma_pkg::ar_req_t           req
);

    localparam int CW = $clog2(FIFO_DEPTH) + 1;
    localparam int AW = vdma_pkg::ASIZE;
    localparam int LW = vdma_pkg::LSIZE;

    // frame in progress, cleared after the last burst
    logic           running;
    logic [15:0]    line_cnt;
    // words of the current line not yet requested
    logic [15:0]    words_left;
    // config captured at frame start
    logic [15:0]    line_words_q;
    logic [15:0]    vactive_q;
    logic [AW-1:0]  stride_q;
    logic [AW-1:0]  line_addr;
    logic [AW-1:0]  burst_addr;
    // requested but not yet in the FIFO
    logic [CW-1:0]  outstanding;
    logic [CW-1:0]  free_words;
    logic [15:0]    next_len;
    logic           issue;
    logic           line_last_burst;
    logic           frame_last_line;

    always_comb begin
        // full burst, or whatever is left as the tail
        next_len = (words_left > 16'(BURST_LEN)) ? 16'(BURST_LEN) : words_left;
        // level plus outstanding never exceeds the depth
        free_words = CW'(FIFO_DEPTH) - level - outstanding;
        issue = running && (words_left != 16'd0) && !ar_busy &&
                (16'(free_words) >= next_len);
        line_last_burst = (next_len == words_left);
        frame_last_line = (line_cnt == vactive_q - 16'd1);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            running     <= 1'b0;
            line_cnt    <= 16'd0;
            words_left  <= 16'd0;
            outstanding <= '0;
            req_valid   <= 1'b0;
        end else if (frame_start) begin
            // restart on every frame, nothing is in flight here
            running     <= 1'b1;
            line_cnt    <= 16'd0;
            words_left  <= cfg.hactive / 16'(vdma_pkg::PIX_PER_WORD);
            outstanding <= '0;
            req_valid   <= 1'b0;
        end else begin
            req_valid   <= issue;
            outstanding <= outstanding + (issue ? CW'(next_len) : '0) - CW'(wr_beat);
            if (issue) begin
                if (!line_last_burst) begin
                    words_left <= words_left - next_len;
                end else if (frame_last_line) begin
                    // frame fully requested, wait for the next one
                    running    <= 1'b0;
                    words_left <= 16'd0;
                end else begin
                    line_cnt   <= line_cnt + 16'd1;
                    words_left <= line_words_q;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (frame_start) begin
            stride_q     <= cfg.line_stride;
            line_words_q <= cfg.hactive / 16'(vdma_pkg::PIX_PER_WORD);
            vactive_q    <= cfg.vactive;
            line_addr    <= cfg.baseaddr;
            burst_addr   <= cfg.baseaddr;
        end else if (issue) begin
            req.addr <= burst_addr;
            req.len  <= LW'(next_len - 16'd1);
            if (line_last_burst) begin
                // next line starts one stride on, regardless of line length
                line_addr  <= line_addr + stride_q;
                burst_addr <= line_addr + stride_q;
            end else begin
                burst_addr <= burst_addr + AW'(next_len) * AW'(vdma_pkg::BYTES_PER_WORD);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/vdma_pkg.sv
`default_nettype none

package vdma_pkg;

    // byte address width on the AXI read channel
    localparam int ASIZE = 32;
    // one read beat
    localparam int AXI_DSIZE = 64;
    // one output pixel
    localparam int DSIZE = 16;
    localparam int PIX_PER_WORD = AXI_DSIZE / DSIZE;
    // arlen field, beats minus one
    localparam int LSIZE = 8;
    // address step per beat
    localparam int BYTES_PER_WORD = AXI_DSIZE / 8;

    typedef logic [DSIZE-1:0] pixel_t;

    // same 64 bits seen as a flat beat or as four pixels
    // pixel 0 sits in the low bits and goes out first
    typedef union packed {
        logic [AXI_DSIZE-1:0]           data;
        pixel_t [PIX_PER_WORD-1:0]      pix;
    } axi_word_t;

    // one burst request toward the AR channel
    typedef struct packed {
        logic [ASIZE-1:0]   addr;
        logic [LSIZE-1:0]   len;
    } ar_req_t;

    // frame geometry and placement in memory
    typedef struct packed {
        logic [31:0]    baseaddr;
        // bytes from one line start to the next
        logic [31:0]    line_stride;
        logic [15:0]    hactive;
        logic [15:0]    vactive;
    } frame_cfg_t;

    typedef struct packed {
        logic   vsync;
        logic   hsync;
        logic   de;
    } sync_t;

endpackage

`default_nettype wire

//--- src/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_BLANK = 32,
    parameter int V_BLANK = 4,
    parameter int HSYNC_W = 8
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    enable,
    input  vdma_pkg::frame_cfg_t    cfg,
    output logic                    frame_start,
    output logic                    pix_rd,
    output vdma_pkg::sync_t         out_sync
);

    // blank comes first on both axes, so 0/0 is the vertical blank start
    logic [15:0]        hcnt;
    logic [15:0]        vcnt;
    // active size of the running frame
    logic [15:0]        hact_q;
    logic [15:0]        vact_q;
    logic               line_end;
    logic               frame_end;
    vdma_pkg::sync_t    sync_nxt;

    always_comb begin
        line_end  = (hcnt == 16'(H_BLANK) + hact_q - 16'd1);
        frame_end = (vcnt == 16'(V_BLANK) + vact_q - 16'd1);
        // counters sit at 0/0 while disabled, so this also marks enable rising
        frame_start = enable && (hcnt == 16'd0) && (vcnt == 16'd0);
        pix_rd = enable && (vcnt >= 16'(V_BLANK)) && (hcnt >= 16'(H_BLANK));
        // vsync for the whole first blank line
        sync_nxt.vsync = (vcnt == 16'd0);
        sync_nxt.hsync = (hcnt < 16'(HSYNC_W));
        sync_nxt.de    = pix_rd;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hcnt <= 16'd0;
            vcnt <= 16'd0;
        end else if (!enable) begin
            hcnt <= 16'd0;
            vcnt <= 16'd0;
        end else if (line_end) begin
            hcnt <= 16'd0;
            vcnt <= frame_end ? 16'd0 : vcnt + 16'd1;
        end else begin
            hcnt <= hcnt + 16'd1;
        end
    end

    // geometry only changes at frame start
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hact_q <= 16'd0;
            vact_q <= 16'd0;
        end else if (frame_start) begin
            hact_q <= cfg.hactive;
            vact_q <= cfg.vactive;
        end
    end

    // one cycle late, lines up with odata
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_sync <= '0;
        end else begin
            out_sync <= enable ? sync_nxt : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/word_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module word_unpacker (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    pix_rd,
    input  vdma_pkg::axi_word_t     fifo_word,
    input  logic                    fifo_empty,
    output logic                    fifo_rd,
    output vdma_pkg::pixel_t        odata
);

    localparam int IW = $clog2(vdma_pkg::PIX_PER_WORD);

    // word being shifted out
    vdma_pkg::axi_word_t    held;
    logic                   held_valid;
    // fifo_word holds a word not yet taken into held
    logic                   nxt_valid;
    logic [IW-1:0]          idx;
    logic                   last_pix;
    logic                   load;

    assign last_pix = pix_rd && (idx == IW'(vdma_pkg::PIX_PER_WORD - 1));
    // refill held when empty or on its last pixel, so no gap between words
    assign load     = nxt_valid && (!held_valid || last_pix);
    // keep the FIFO output stage topped up
    assign fifo_rd  = !fifo_empty && (!nxt_valid || load);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            nxt_valid  <= 1'b0;
            idx        <= '0;
        end else begin
            if (pix_rd) begin
                idx <= last_pix ? '0 : idx + 1'b1;
            end
            if (load) begin
                held_valid <= 1'b1;
            end else if (last_pix) begin
                held_valid <= 1'b0;
            end
            // new word lands in fifo_word together with this flag
            if (fifo_rd) begin
                nxt_valid <= 1'b1;
            end else if (load) begin
                nxt_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            held <= fifo_word;
        end
        // pixel view, low pixel first
        if (pix_rd) begin
            odata <= held.pix[idx];
        end
    end

endmodule

`default_nettype wire

//--- tests/frame_reader_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module frame_reader_asserts #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        axi_arvalid,
    input  logic                        axi_arready,
    input  logic [vdma_pkg::ASIZE-1:0]  axi_araddr,
    input  logic [vdma_pkg::LSIZE-1:0]  axi_arlen,
    input  logic                        wr_beat,
    input  logic [$clog2(FIFO_DEPTH):0] level,
    input  logic                        fifo_rd,
    input  logic                        fifo_empty
);

    // failures seen, read back by the testbench
    int fails = 0;

    // address phase held until arready
    ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        axi_arvalid && !axi_arready |=>
            axi_arvalid && $stable(axi_araddr) && $stable(axi_arlen))
        else begin
            $error("AR address or length changed before the handshake");
            fails++;
        end

    // R beat accepted into a full FIFO
    no_full_write: assert property (@(posedge clock) disable iff (!rst_n)
        !(wr_beat && (level == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH))))
        else begin
            $error("FIFO written while full");
            fails++;
        end

    no_empty_read: assert property (@(posedge clock) disable iff (!rst_n)
        !(fifo_rd && fifo_empty))
        else begin
            $error("FIFO read while empty");
            fails++;
        end

endmodule

// internal FIFO and AR nets are visible at the top level
bind frame_reader_top frame_reader_asserts #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_asserts (
    .clock       (clock),
    .rst_n       (rst_n),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .wr_beat     (wr_beat),
    .level       (level),
    .fifo_rd     (fifo_rd),
    .fifo_empty  (fifo_empty)
);

`default_nettype wire

//--- tests/frame_reader_checker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_reader_checker #(
    parameter int BURST_LEN = 16,
    parameter int V_BLANK   = 4
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        enable,
    input  logic                        frame_start,
    input  vdma_pkg::frame_cfg_t        cfg,
    input  vdma_pkg::sync_t             out_sync,
    input  vdma_pkg::pixel_t            odata,
    input  logic                        axi_arvalid,
    input  logic                        axi_arready,
    input  logic [vdma_pkg::ASIZE-1:0]  axi_araddr,
    input  logic [vdma_pkg::LSIZE-1:0]  axi_arlen,
    input  logic [2:0]                  axi_arsize,
    input  logic [1:0]                  axi_arburst
);

    int errors = 0;
    int frame_starts = 0;
    int frames_done = 0;
    int bursts = 0;

    // model copy of the config taken at frame start
    vdma_pkg::frame_cfg_t   m_cfg;
    logic                   frame_open = 1'b0;
    // outputs are defined from the first reset edge on
    logic                   rst_seen = 1'b0;
    logic                   en_d = 1'b0;
    logic                   de_d = 1'b0;
    logic                   hs_d = 1'b0;
    logic                   vs_d = 1'b0;
    // pixel position in the active region
    int                     x;
    int                     y;
    int                     run;
    int                     hs_cnt;
    int                     vs_cnt;
    int                     px_cnt;
    int                     fr_bursts;
    int                     fr_err;
    // burst position, line and word within the line
    int                     b_line;
    int                     b_word;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_fail(input string msg);
        $display("** Error: %s at %0t", msg, $time);
        errors++;
    endtask

    task automatic check_pixel();
        logic [31:0]        addr;
        vdma_pkg::pixel_t   exp;
        // pixel x of line y sits at its own byte address
        addr = m_cfg.baseaddr + 32'(y) * m_cfg.line_stride + 32'(2 * x);
        exp  = 16'(addr >> 1);
        if (odata !== exp) begin
            report_mismatch("odata", 64'(odata), 64'(exp));
        end
        x++;
        run++;
        px_cnt++;
        if (x == int'(m_cfg.hactive)) begin
            x = 0;
            y++;
        end
    endtask

    task automatic check_burst();
        int             lw;
        int             beats;
        logic [31:0]    exp;
        lw    = int'(m_cfg.hactive) / vdma_pkg::PIX_PER_WORD;
        beats = int'(axi_arlen) + 1;
        exp   = m_cfg.baseaddr + 32'(b_line) * m_cfg.line_stride +
                32'(b_word * vdma_pkg::BYTES_PER_WORD);
        if (axi_araddr !== exp) begin
            report_mismatch("axi_araddr", 64'(axi_araddr), 64'(exp));
        end
        // 8-byte beats, INCR addressing
        if (axi_arsize !== 3'd3) begin
            report_mismatch("axi_arsize", 64'(axi_arsize), 64'd3);
        end
        if (axi_arburst !== 2'b01) begin
            report_mismatch("axi_arburst", 64'(axi_arburst), 64'd1);
        end
        if (beats > BURST_LEN) begin
            report_fail("read burst longer than the burst limit");
        end
        if (b_word + beats > lw) begin
            report_fail("read burst runs past the end of its line");
        end
        b_word = b_word + beats;
        if (b_word >= lw) begin
            b_word = 0;
            b_line++;
        end
        bursts++;
        fr_bursts++;
    endtask

    task automatic close_frame();
        // last line ends right at the frame boundary
        if (run != 0 && run != int'(m_cfg.hactive)) begin
            report_mismatch("de run", 64'(run), 64'(m_cfg.hactive));
        end
        if (y != int'(m_cfg.vactive) || x != 0) begin
            report_mismatch("active lines", 64'(y), 64'(m_cfg.vactive));
        end
        if (hs_cnt != int'(m_cfg.vactive) + V_BLANK) begin
            report_mismatch("hsync pulses", 64'(hs_cnt), 64'(int'(m_cfg.vactive) + V_BLANK));
        end
        if (vs_cnt != 1) begin
            report_mismatch("vsync pulses", 64'(vs_cnt), 64'd1);
        end
        if (b_line != int'(m_cfg.vactive) || b_word != 0) begin
            report_fail("bursts of the frame do not cover all lines");
        end
        $display("frame %0d: hactive %0d, %0d pixels, %0d bursts, %0d errors",
                 frames_done, m_cfg.hactive, px_cnt, fr_bursts, errors - fr_err);
        frames_done++;
    endtask

    always @(posedge clock) begin
        // quiet outputs from the first reset edge until enabled
        if (rst_seen && !en_d) begin
            if (out_sync !== '0) begin
                report_mismatch("out_sync", 64'(out_sync), 64'd0);
            end
            if (axi_arvalid !== 1'b0) begin
                report_mismatch("axi_arvalid", 64'(axi_arvalid), 64'd0);
            end
        end
        if (frame_open) begin
            if (out_sync.de) begin
                check_pixel();
            end else if (de_d) begin
                if (run != int'(m_cfg.hactive)) begin
                    report_mismatch("de run", 64'(run), 64'(m_cfg.hactive));
                end
                run = 0;
            end
            if (out_sync.hsync && !hs_d) begin
                hs_cnt++;
            end
            if (out_sync.vsync && !vs_d) begin
                vs_cnt++;
            end
            if (axi_arvalid && axi_arready) begin
                check_burst();
            end
        end
        de_d = out_sync.de;
        if (frame_start) begin
            if (frame_open) begin
                close_frame();
            end
            frame_starts++;
            // same edge the DUT latches cfg
            m_cfg = cfg;
            x = 0;
            y = 0;
            run = 0;
            de_d = 1'b0;
            hs_cnt = 0;
            vs_cnt = 0;
            px_cnt = 0;
            fr_bursts = 0;
            fr_err = errors;
            b_line = 0;
            b_word = 0;
            frame_open = 1'b1;
        end
        if (!rst_n) begin
            rst_seen = 1'b1;
        end
        en_d = enable;
        hs_d = out_sync.hsync;
        vs_d = out_sync.vsync;
    end

endmodule

`default_nettype wire

//--- tests/tb_frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_reader;

    localparam int BURST_LEN  = 16;
    localparam int FIFO_DEPTH = 64;
    localparam int H_BLANK    = 32;
    localparam int V_BLANK    = 4;
    localparam int HSYNC_W    = 8;
    localparam int NCFG       = 4;
    localparam int VACT       = 6;
    localparam int RESET_CYC  = 16;
    // longest frame, hactive 72
    localparam int FRAME_CYC  = (V_BLANK + VACT) * (H_BLANK + 72);
    localparam int LIMIT      = 3 * FRAME_CYC * NCFG + RESET_CYC + 2000;

    logic                           clock;
    logic                           rst_n;
    logic                           enable;
    vdma_pkg::frame_cfg_t           cfg;
    logic                           axi_arready;
    vdma_pkg::axi_word_t            axi_rdata;
    logic [1:0]                     axi_rresp;
    logic                           axi_rlast;
    logic                           axi_rvalid;
    logic [vdma_pkg::ASIZE-1:0]     axi_araddr;
    logic [vdma_pkg::LSIZE-1:0]     axi_arlen;
    logic [2:0]                     axi_arsize;
    logic [1:0]                     axi_arburst;
    logic                           axi_arvalid;
    logic                           axi_rready;
    vdma_pkg::sync_t                out_sync;
    vdma_pkg::pixel_t               odata;
    logic                           frame_start_mon;

    logic [31:0]                    lfsr;
    int                             cycles = 0;
    // slave model state
    int unsigned                    ar_wait;
    logic [31:0]                    q_addr[$];
    logic [7:0]                     q_len[$];
    logic [31:0]                    r_addr;
    int unsigned                    r_beats;
    logic                           r_hold;
    int                             total;

    frame_reader_top #(
        .BURST_LEN  (BURST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH),
        .H_BLANK    (H_BLANK),
        .V_BLANK    (V_BLANK),
        .HSYNC_W    (HSYNC_W)
    ) UUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .cfg         (cfg),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rlast   (axi_rlast),
        .axi_rvalid  (axi_rvalid),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arvalid (axi_arvalid),
        .axi_rready  (axi_rready),
        .out_sync    (out_sync),
        .odata       (odata)
    );

    assign frame_start_mon = UUT.frame_start;

    frame_reader_checker #(
        .BURST_LEN (BURST_LEN),
        .V_BLANK   (V_BLANK)
    ) u_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .frame_start (frame_start_mon),
        .cfg         (cfg),
        .out_sync    (out_sync),
        .odata       (odata),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst)
    );

    // galois shift, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // even configs 72 pixels wide, odd ones 64
    function automatic vdma_pkg::frame_cfg_t make_cfg(input int k);
        vdma_pkg::frame_cfg_t   c;
        logic [31:0]            base_bits;
        logic [31:0]            stride_bits;
        base_bits     = rand_bits(16);
        stride_bits   = rand_bits(8);
        c.baseaddr    = base_bits << 3;
        c.line_stride = 32'd256 + (stride_bits << 3);
        c.hactive     = (k % 2 == 0) ? 16'd72 : 16'd64;
        c.vactive     = 16'(VACT);
        return c;
    endfunction

    // every pixel carries its own byte address halved
    function automatic vdma_pkg::axi_word_t make_word(input logic [31:0] addr);
        vdma_pkg::axi_word_t w;
        for (int i = 0; i < vdma_pkg::PIX_PER_WORD; i++) begin
            w.data[16*i +: 16] = 16'((addr + 32'(2 * i)) >> 1);
        end
        return w;
    endfunction

    task automatic wait_frames(input int n);
        while (u_checker.frame_starts < n) begin
            @(negedge clock);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // handshakes seen on the rising edge
    always @(posedge clock) begin
        if (axi_arvalid && axi_arready) begin
            q_addr.push_back(axi_araddr);
            q_len.push_back(axi_arlen);
        end
        r_hold = axi_rvalid && !axi_rready;
        if (axi_rvalid && axi_rready) begin
            r_addr  = r_addr + 32'(vdma_pkg::BYTES_PER_WORD);
            r_beats = r_beats - 1;
        end
    end

    // slave drives AR ready and R beats on the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            if (axi_arvalid && !axi_arready) begin
                if (ar_wait == 0) begin
                    axi_arready = 1'b1;
                end else begin
                    ar_wait = ar_wait - 1;
                end
            end else if (axi_arready) begin
                axi_arready = 1'b0;
                ar_wait = rand_bits(2);
            end
            // a stalled beat stays put
            if (!r_hold) begin
                if (r_beats == 0 && q_addr.size() != 0) begin
                    r_addr  = q_addr.pop_front();
                    r_beats = int'(q_len.pop_front()) + 1;
                end
                if (r_beats != 0 && rand_bits(2) != 0) begin
                    axi_rvalid = 1'b1;
                    axi_rdata  = make_word(r_addr);
                    axi_rlast  = (r_beats == 1);
                end else begin
                    axi_rvalid = 1'b0;
                    axi_rlast  = 1'b0;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: frames did not finish within %0d cycles", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        lfsr        = 32'h2451;
        rst_n       = 1'b0;
        enable      = 1'b0;
        cfg         = '0;
        axi_arready = 1'b0;
        axi_rdata   = '0;
        axi_rresp   = 2'b00;
        axi_rlast   = 1'b0;
        axi_rvalid  = 1'b0;
        ar_wait     = 0;
        r_addr      = '0;
        r_beats     = 0;
        r_hold      = 1'b0;
        repeat (RESET_CYC) @(negedge clock);
        rst_n = 1'b1;
        cfg = make_cfg(0);
        @(negedge clock);
        enable = 1'b1;
        // two frames per config, the change lands mid frame
        for (int k = 1; k < NCFG; k++) begin
            wait_frames(2 * k);
            repeat (500) @(negedge clock);
            cfg = make_cfg(k);
        end
        // one more start closes the last frame
        wait_frames(2 * NCFG + 1);
        total = u_checker.errors + UUT.u_asserts.fails;
        $display("summary: %0d frames, %0d bursts, %0d errors",
                 u_checker.frames_done, u_checker.bursts, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
